//--- bench/lsu_tb.sv
// LSU testbench
// Random requests checked against a byte-memory model

module lsu_tb import lsu_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int NUM_REQ = 2000;
   localparam int TIMEOUT = 1000;  // Cycles per wait

   logic               clk, arst_n;
   logic               req_valid, req_ready;
   logic [31:0]        req_base;
   logic signed [11:0] req_offset;
   logic               req_store;
   ls_size_e           req_size;
   logic               req_unsigned;
   logic [31:0]        req_wdata;
   logic               rsp_valid, rsp_ready;
   lsu_err_e           rsp_err;
   logic [31:0]        rsp_data;

   logic [7:0]  mem_model [DCCM_BYTES];  // Byte image of the DCCM
   lsu_err_e    exp_err_q [$];           // Expected responses in order
   logic [31:0] exp_data_q [$];
   int          acc_cyc_q [$];           // Accepting cycle per request
   bit          rdy_hist [int];          // rsp_ready seen in each cycle
   int          cycle, num_acc, num_rsp;
   bit          drain_mode;              // Hold rsp_ready high at the end

   tb_clk_gen clk_gen_inst (
      .clk    (clk),
      .arst_n (arst_n)
   );

   lsu_top lsu_top_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_base     (req_base),
      .req_offset   (req_offset),
      .req_store    (req_store),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_wdata    (req_wdata),
      .rsp_valid    (rsp_valid),
      .rsp_ready    (rsp_ready),
      .rsp_err      (rsp_err),
      .rsp_data     (rsp_data)
   );

   // ************************************************************
   // Error reporting
   // ************************************************************
   task automatic stop_run();
      $display("*** TEST FAILED ***");
      $fatal(1, "Stopped at the first error");
   endtask

   task automatic fail_value(input string test, input logic [31:0] exp, input logic [31:0] act);
      $display("ERROR %s: expected %08h, actual %08h", test, exp, act);
      stop_run();
   endtask

   task automatic fail_plain(input string what);
      $display("%s", what);
      stop_run();
   endtask

   // ************************************************************
   // Reference model
   // ************************************************************
   // Expected result of the request on the inputs, memory updated in order
   task automatic model_accept();
      logic [31:0] addr, off, word;
      int          nbytes, base_idx;
      lsu_err_e    err;
      addr   = req_base + 32'($signed(req_offset));
      nbytes = (req_size == LS_BYTE) ? 1 : (req_size == LS_HALF) ? 2 : 4;
      err    = ERR_NONE;
      word   = '0;
      if ((addr & 32'(nbytes - 1)) != 0) begin
         err = ERR_MISALIGN;  // Alignment wins over region
      end else begin
         for (int i = 0; i < nbytes; i++) begin
            off = addr + 32'(i) - DCCM_BASE;
            if (off >= 32'(DCCM_BYTES)) err = ERR_ACCESS;
         end
      end
      if (err == ERR_NONE) begin
         base_idx = int'(addr - DCCM_BASE);
         for (int i = 0; i < nbytes; i++) begin
            if (req_store) mem_model[base_idx + i] = req_wdata[8*i +: 8];  // Little endian
            else           word[8*i +: 8] = mem_model[base_idx + i];
         end
         if (!req_store && !req_unsigned && (nbytes == 1)) word = {{24{word[7]}}, word[7:0]};
         if (!req_store && !req_unsigned && (nbytes == 2)) word = {{16{word[15]}}, word[15:0]};
         if (req_store) word = '0;  // Stores answer with zero
      end
      exp_err_q.push_back(err);
      exp_data_q.push_back(word);
      acc_cyc_q.push_back(cycle);
      num_acc++;
   endtask

   task automatic check_response();
      lsu_err_e    exp_err;
      logic [31:0] exp_data;
      int          acc_cyc;
      assert (exp_err_q.size() != 0)
         else fail_plain("A response arrived with no request outstanding");
      exp_err  = exp_err_q.pop_front();
      exp_data = exp_data_q.pop_front();
      acc_cyc  = acc_cyc_q.pop_front();
      num_rsp++;
      assert (rsp_err == exp_err) else fail_value("rsp_err", 32'(exp_err), 32'(rsp_err));
      assert (rsp_data == exp_data) else fail_value("rsp_data", exp_data, rsp_data);
      assert (cycle >= acc_cyc + 2) else fail_value("rsp_latency_min", acc_cyc + 2, cycle);
      // Unstalled path gives the response exactly two cycles on
      if (rdy_hist[acc_cyc + 1] && rdy_hist[acc_cyc + 2]) begin
         assert (cycle == acc_cyc + 2) else fail_value("rsp_latency", acc_cyc + 2, cycle);
      end
   endtask

   // ************************************************************
   // Cycle stepping and stimulus
   // ************************************************************
   // Sample handshakes mid-cycle, then drive just after the next edge
   task automatic step_cycle(output bit acc);
      bit rsp;
      @(negedge clk);
      acc = req_valid && req_ready;
      rsp = rsp_valid && rsp_ready;
      rdy_hist[cycle] = rsp_ready;
      // A stalled response closes the request side
      assert (!(rsp_valid && !rsp_ready) || !req_ready)
         else fail_value("req_ready", 32'd0, 32'(req_ready));
      if (rsp) check_response();  // Older request first
      if (acc) model_accept();
      @(posedge clk);
      #1;
      cycle++;
      rsp_ready = drain_mode || ($urandom % 4 != 0);  // Random back-pressure
   endtask

   task automatic drive_request();
      logic [31:0] target;
      logic [11:0] offset;
      int          pick;
      pick = $urandom % 100;
      if (pick < 90)      target = DCCM_BASE + ($urandom % 64);  // Hot region, collisions
      else if (pick < 94) target = DCCM_BASE + DCCM_BYTES - 4 + ($urandom % 8);  // Around the end
      else if (pick < 97) target = DCCM_BASE - 1 - ($urandom % 16);  // Just below
      else                target = $urandom;
      offset       = 12'($urandom);
      req_offset   = offset;
      req_base     = target - 32'($signed(offset));  // Base plus offset hits target
      req_store    = 1'($urandom);
      req_size     = ls_size_e'(2'($urandom % 3));
      req_unsigned = 1'($urandom);
      req_wdata    = $urandom;
      req_valid    = 1'b1;
   endtask

   initial begin
      bit acc;
      int waited, idle;
      void'($urandom(2170));
      req_valid    = 1'b0;
      req_base     = '0;
      req_offset   = '0;
      req_store    = 1'b0;
      req_size     = LS_BYTE;
      req_unsigned = 1'b0;
      req_wdata    = '0;
      rsp_ready    = 1'b1;
      drain_mode   = 1'b0;
      cycle        = 0;
      num_acc      = 0;
      num_rsp      = 0;
      for (int i = 0; i < DCCM_BYTES; i++) mem_model[i] = 8'h00;  // DCCM clears on reset

      waited = 0;
      while (!arst_n) begin
         if (waited == TIMEOUT) fail_plain("Reset was never released");
         @(posedge clk);
         waited++;
      end
      @(posedge clk);
      #1;

      for (int n = 0; n < NUM_REQ; n++) begin
         idle = ($urandom % 4 == 0) ? 1 + ($urandom % 2) : 0;  // Mostly back to back
         for (int i = 0; i < idle; i++) step_cycle(acc);
         drive_request();
         acc    = 1'b0;
         waited = 0;
         while (!acc) begin  // Valid and data held until accepted
            if (waited == TIMEOUT) fail_plain("A request was not accepted in time");
            step_cycle(acc);
            waited++;
         end
         req_valid = 1'b0;
      end

      // Drain period with the consumer always ready
      drain_mode = 1'b1;
      rsp_ready  = 1'b1;
      waited     = 0;
      while ((exp_err_q.size() != 0) && (waited < TIMEOUT)) begin
         step_cycle(acc);
         waited++;
      end
      for (int i = 0; i < 20; i++) step_cycle(acc);  // Catches duplicates

      if ((num_rsp == num_acc) && (exp_err_q.size() == 0)) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         fail_value("queue_count", num_acc, num_rsp);
      end
   end

endmodule

//--- bench/tb_clk_gen.sv
// Testbench clock and reset

module tb_clk_gen (
   output logic clk,
   output logic arst_n
);
   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   initial begin
      arst_n = 1'b0;
      repeat (4) @(posedge clk);
      #1 arst_n = 1'b1;  // Release off the edge
   end

endmodule

//--- lsu_top.f
src/lsu_pkg.sv
src/dccm_if.sv
src/stbuf_fwd_if.sv
src/lsu_lsc_ctl.sv
src/lsu_stbuf.sv
src/lsu_dccm.sv
src/lsu_top.sv
bench/tb_clk_gen.sv
bench/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module lsu_tb -f lsu_top.f -o lsu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/lsu_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***'; then
   exit 0
fi
exit 1

//--- src/dccm_if.sv
// DCCM port

interface dccm_if import lsu_pkg::*; ();

   logic                      rden;     // Read request
   logic                      wren;     // Write request
   logic [DCCM_WIDX_BITS-1:0] addr;     // Word index
   logic [3:0]                wbyteen;  // Byte lanes to write
   logic [31:0]               wdata;
   logic [31:0]               rdata;    // Registered read data
   logic                      grant;    // Port owns the array this cycle

   modport requester (
      output rden, wren, addr, wbyteen, wdata,
      input  rdata, grant
   );

   modport memory (
      input  rden, wren, addr, wbyteen, wdata,
      output rdata, grant
   );

endinterface

//--- src/lsu_dccm.sv
// DCCM array with one shared port

module lsu_dccm import lsu_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   dccm_if.memory rd,
   dccm_if.memory wr
);

   logic [31:0]               mem [DCCM_WORDS];
   logic [31:0]               rdata_q;
   logic                      rd_act, wr_req;
   logic                      rden, wren;
   logic [DCCM_WIDX_BITS-1:0] addr;
   logic [3:0]                wbyteen;
   logic [31:0]               wdata;

   // Load port first, drain port takes idle cycles
   assign rd_act   = rd.rden | rd.wren;
   assign wr_req   = wr.rden | wr.wren;
   assign rd.grant = rd_act;
   assign wr.grant = wr_req & ~rd_act;

   assign rden    = rd_act ? rd.rden    : wr.rden;
   assign wren    = rd_act ? rd.wren    : wr.wren;
   assign addr    = rd_act ? rd.addr    : wr.addr;
   assign wbyteen = rd_act ? rd.wbyteen : wr.wbyteen;
   assign wdata   = rd_act ? rd.wdata   : wr.wdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < DCCM_WORDS; i++) begin
            mem[i] <= '0;
         end
         rdata_q <= '0;
      end else begin
         if (rden) rdata_q <= mem[addr];  // Held between reads
         if (wren) begin
            for (int b = 0; b < 4; b++) begin
               if (wbyteen[b]) mem[addr][8*b +: 8] <= wdata[8*b +: 8];
            end
         end
      end
   end

   assign rd.rdata = rdata_q;
   assign wr.rdata = rdata_q;

endmodule

//--- src/lsu_lsc_ctl.sv
// LSU pipeline control
// Address check, stage registers and load alignment

module lsu_lsc_ctl import lsu_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   input  logic               req_valid,
   output logic               req_ready,
   input  logic [31:0]        req_base,
   input  logic signed [11:0] req_offset,
   input  logic               req_store,
   input  ls_size_e           req_size,
   input  logic               req_unsigned,
   input  logic [31:0]        req_wdata,
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output lsu_err_e           rsp_err,
   output logic [31:0]        rsp_data,
   stbuf_fwd_if.requester     fwd,
   dccm_if.requester          rd
);

   logic [31:0]               addr_d, end_d;      // First and last byte
   logic [31:0]               off_d, end_off_d;   // Same, relative to DCCM base
   logic                      misalign_d, in_dccm_d;
   logic                      accept_d;
   logic [DCCM_WIDX_BITS-1:0] widx_d, widx_m;
   lsu_pkt_t                  pkt_d, pkt_m, pkt_r;
   logic                      hold_m;
   logic [3:0]                be_m;
   logic [31:0]               merged_m;
   logic [31:0]               lane_r, ext_r;

   // ************************************************************
   // D stage
   // ************************************************************
   assign addr_d = req_base + {{20{req_offset[11]}}, req_offset};

   always_comb begin
      case (req_size)
         LS_HALF: end_d = addr_d + 32'd1;
         LS_WORD: end_d = addr_d + 32'd3;
         default: end_d = addr_d;
      endcase
   end

   assign off_d     = addr_d - DCCM_BASE;  // Wraps high below the base
   assign end_off_d = end_d - DCCM_BASE;
   assign in_dccm_d = (off_d < DCCM_BYTES) && (end_off_d < DCCM_BYTES);
   assign widx_d    = off_d[DCCM_BITS-1:2];

   assign misalign_d = ((req_size == LS_HALF) && addr_d[0]) ||
                       ((req_size == LS_WORD) && (addr_d[1:0] != 2'b00));

   always_comb begin
      pkt_d.valid  = accept_d;  // Bubble when nothing accepted
      pkt_d.store  = req_store;
      pkt_d.unsign = req_unsigned;
      pkt_d.size   = req_size;
      pkt_d.boff   = addr_d[1:0];
      pkt_d.data   = req_wdata << {addr_d[1:0], 3'b000};  // Into byte lanes
      // Alignment is checked ahead of the region
      if (misalign_d) begin
         pkt_d.err = ERR_MISALIGN;
      end else if (!in_dccm_d) begin
         pkt_d.err = ERR_ACCESS;
      end else begin
         pkt_d.err = ERR_NONE;
      end
   end

   // Accept only when M can move and the buffer has room
   assign req_ready = ~hold_m & ~fwd.full;
   assign accept_d  = req_valid & req_ready;

   // Load port read in the accepting cycle
   assign rd.rden    = accept_d & ~req_store & (pkt_d.err == ERR_NONE);
   assign rd.addr    = widx_d;
   assign rd.wren    = 1'b0;  // Load port never writes
   assign rd.wbyteen = '0;
   assign rd.wdata   = '0;

   // Stage registers, M and R move together
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pkt_m  <= '0;
         pkt_r  <= '0;
         widx_m <= '0;
      end else if (!hold_m) begin
         pkt_m       <= pkt_d;
         widx_m      <= widx_d;
         pkt_r       <= pkt_m;
         pkt_r.data  <= merged_m;   // Load word replaces store data
      end
   end

   // ************************************************************
   // M stage
   // ************************************************************
   assign hold_m = pkt_r.valid & ~rsp_ready;  // R stalled by the consumer

   always_comb begin
      case (pkt_m.size)
         LS_BYTE: be_m = 4'b0001 << pkt_m.boff;
         LS_HALF: be_m = 4'b0011 << pkt_m.boff;
         default: be_m = 4'b1111;
      endcase
   end

   // Store enters the buffer on the edge that ends M
   assign fwd.push        = pkt_m.valid & pkt_m.store & (pkt_m.err == ERR_NONE) & ~hold_m;
   assign fwd.push_widx   = widx_m;
   assign fwd.push_be     = be_m;
   assign fwd.push_data   = pkt_m.data;
   assign fwd.lookup_addr = widx_m;
   assign fwd.hold        = hold_m;  // Blocks drain under a held load

   // Buffered bytes win over the DCCM word
   always_comb begin
      for (int b = 0; b < 4; b++) begin
         merged_m[8*b +: 8] = fwd.fwd_byteen[b] ? fwd.fwd_data[8*b +: 8] : rd.rdata[8*b +: 8];
      end
   end

   // ************************************************************
   // R stage
   // ************************************************************
   assign lane_r = pkt_r.data >> {pkt_r.boff, 3'b000};  // Addressed byte to lane 0

   always_comb begin
      case (pkt_r.size)
         LS_BYTE: ext_r = {{24{~pkt_r.unsign & lane_r[7]}}, lane_r[7:0]};
         LS_HALF: ext_r = {{16{~pkt_r.unsign & lane_r[15]}}, lane_r[15:0]};
         default: ext_r = lane_r;
      endcase
   end

   assign rsp_valid = pkt_r.valid;
   assign rsp_err   = pkt_r.err;
   assign rsp_data  = (pkt_r.store || (pkt_r.err != ERR_NONE)) ? '0 : ext_r;  // Loads only

endmodule

//--- src/lsu_pkg.sv
// Load/store unit shared definitions

package lsu_pkg;

   // DCCM address map
   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;  // First byte of the DCCM
   localparam int DCCM_BYTES = 4096;                   // DCCM size in bytes
   localparam int DCCM_BITS = 12;                      // Byte address bits inside the DCCM
   localparam int DCCM_WORDS = 1024;                   // Number of 32-bit words
   localparam int DCCM_WIDX_BITS = 10;                 // Word index width

   localparam int STBUF_DEPTH = 4;                     // Default store buffer entries

   // Access size
   typedef enum logic [1:0] {
      LS_BYTE = 2'd0,
      LS_HALF = 2'd1,
      LS_WORD = 2'd2
   } ls_size_e;

   // Response error code
   typedef enum logic [1:0] {
      ERR_NONE     = 2'd0,
      ERR_MISALIGN = 2'd1,  // Half at odd address or word off a 4-byte boundary
      ERR_ACCESS   = 2'd2   // Some byte outside the DCCM
   } lsu_err_e;

   // Per-stage packet
   typedef struct packed {
      logic        valid;
      logic        store;
      logic        unsign;  // Zero-extend loads
      ls_size_e    size;
      lsu_err_e    err;
      logic [1:0]  boff;    // Byte offset inside the word
      logic [31:0] data;    // Store data in lanes, load word from M on
   } lsu_pkt_t;

endpackage

//--- src/lsu_stbuf.sv
// Store buffer with forwarding and drain

module lsu_stbuf import lsu_pkg::*; #(
   parameter int DEPTH = STBUF_DEPTH
) (
   input  logic        clk,
   input  logic        arst_n,
   stbuf_fwd_if.buffer fwd,
   dccm_if.requester   wr
);

   // Entry storage
   logic [DCCM_WIDX_BITS-1:0]  widx_q [DEPTH];
   logic [3:0]                 be_q   [DEPTH];
   logic [31:0]                data_q [DEPTH];

   logic [$clog2(DEPTH)-1:0]   wr_ptr, rd_ptr;
   logic [$clog2(DEPTH+1)-1:0] count;         // Occupied entries
   logic                       pop;

   function automatic logic [$clog2(DEPTH)-1:0] ptr_inc(input logic [$clog2(DEPTH)-1:0] p);
      return (int'(p) == DEPTH - 1) ? '0 : p + 1'b1;  // Wrap for any depth
   endfunction

   always_ff @(posedge clk) begin
      if (fwd.push) begin
         widx_q[wr_ptr] <= fwd.push_widx;
         be_q[wr_ptr]   <= fwd.push_be;
         data_q[wr_ptr] <= fwd.push_data;
      end
   end

   assign pop = wr.grant;  // Oldest entry written this cycle

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (fwd.push) wr_ptr <= ptr_inc(wr_ptr);
         if (pop)      rd_ptr <= ptr_inc(rd_ptr);
         case ({fwd.push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: ;  // Both or neither
         endcase
      end
   end

   // A store meeting a full buffer in M pops the oldest entry on the same edge
   assign fwd.full = (int'(count) == DEPTH);

   // ************************************************************
   // Byte-wise forwarding, oldest to newest so newer bytes win
   // ************************************************************
   always_comb begin
      int idx;
      fwd.fwd_byteen = '0;
      fwd.fwd_data   = '0;
      for (int k = 0; k < DEPTH; k++) begin
         idx = int'(rd_ptr) + k;
         if (idx >= DEPTH) idx = idx - DEPTH;
         if ((k < int'(count)) && (widx_q[idx] == fwd.lookup_addr)) begin
            for (int b = 0; b < 4; b++) begin
               if (be_q[idx][b]) begin
                  fwd.fwd_byteen[b]     = 1'b1;
                  fwd.fwd_data[8*b +: 8] = data_q[idx][8*b +: 8];
               end
            end
         end
      end
   end

   // Drain the oldest entry, never under a held M stage
   assign wr.wren    = (count != '0) & ~fwd.hold;
   assign wr.rden    = 1'b0;
   assign wr.addr    = widx_q[rd_ptr];
   assign wr.wbyteen = be_q[rd_ptr];
   assign wr.wdata   = data_q[rd_ptr];

endmodule

//--- src/lsu_top.sv
// Load/store unit top level

module lsu_top import lsu_pkg::*; (
   input  logic               clk,
   input  logic               arst_n,
   // Request
   input  logic               req_valid,
   output logic               req_ready,
   input  logic [31:0]        req_base,
   input  logic signed [11:0] req_offset,
   input  logic               req_store,
   input  ls_size_e           req_size,
   input  logic               req_unsigned,
   input  logic [31:0]        req_wdata,
   // Response
   output logic               rsp_valid,
   input  logic               rsp_ready,
   output lsu_err_e           rsp_err,
   output logic [31:0]        rsp_data
);

   dccm_if      load_port ();   // Pipeline reads
   dccm_if      drain_port ();  // Store buffer writes
   stbuf_fwd_if fwd_bus ();

   lsu_lsc_ctl lsc_ctl_inst (
      .clk          (clk),
      .arst_n       (arst_n),
      .req_valid    (req_valid),
      .req_ready    (req_ready),
      .req_base     (req_base),
      .req_offset   (req_offset),
      .req_store    (req_store),
      .req_size     (req_size),
      .req_unsigned (req_unsigned),
      .req_wdata    (req_wdata),
      .rsp_valid    (rsp_valid),
      .rsp_ready    (rsp_ready),
      .rsp_err      (rsp_err),
      .rsp_data     (rsp_data),
      .fwd          (fwd_bus),
      .rd           (load_port)
   );

   lsu_stbuf #(.DEPTH(STBUF_DEPTH)) stbuf_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .fwd    (fwd_bus),
      .wr     (drain_port)
   );

   lsu_dccm dccm_inst (
      .clk    (clk),
      .arst_n (arst_n),
      .rd     (load_port),
      .wr     (drain_port)
   );

endmodule

//--- src/stbuf_fwd_if.sv
// Store buffer push and forwarding lookup

interface stbuf_fwd_if import lsu_pkg::*; ();

   logic                      push;         // Error-free store leaving M
   logic [DCCM_WIDX_BITS-1:0] push_widx;
   logic [3:0]                push_be;
   logic [31:0]               push_data;
   logic [DCCM_WIDX_BITS-1:0] lookup_addr;  // Word index of the load in M
   logic                      hold;         // M stage stalled
   logic [3:0]                fwd_byteen;   // Lanes found in the buffer
   logic [31:0]               fwd_data;
   logic                      full;

   modport requester (
      output push, push_widx, push_be, push_data, lookup_addr, hold,
      input  fwd_byteen, fwd_data, full
   );

   modport buffer (
      input  push, push_widx, push_be, push_data, lookup_addr, hold,
      output fwd_byteen, fwd_data, full
   );

endinterface
